// ==== source/fifo_cfg_pkg.sv ====
`default_nettype none

package fifo_cfg_pkg;

  // Width of one word.
  localparam int DATA_WIDTH = 8;

  // Number of storage entries.
  localparam int FIFO_DEPTH = 16;

  // Memory address width.
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // One extra bit tells a full FIFO from an empty one.
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // Flag thresholds, in words.
  localparam int FIFO_AFULL  = 14;
  localparam int FIFO_AEMPTY = 2;

endpackage

`default_nettype wire

// ==== source/fifo_types_pkg.sv ====
`default_nettype none

package fifo_types_pkg;

  import fifo_cfg_pkg::*;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Binary or Gray, wrap bit on top.
  typedef logic [PTR_WIDTH-1:0] ptr_t;

  // Occupancy, 0 up to FIFO_DEPTH.
  typedef logic [PTR_WIDTH-1:0] level_t;

endpackage

`default_nettype wire

// ==== source/fifo_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo_ram (
  input  wire                          wr_clk,
  input  wire                          wr_accept,
  input  wire fifo_types_pkg::addr_t   wr_addr,
  input  wire fifo_types_pkg::data_t   wr_data,
  input  wire                          rd_clk,
  input  wire                          rd_accept,
  input  wire fifo_types_pkg::addr_t   rd_addr,
  output fifo_types_pkg::data_t        rd_data
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  // Storage array.
  data_t mem [FIFO_DEPTH];

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port holds its word until the next accepted read.
  always_ff @(posedge rd_clk) begin
    if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== source/ptr_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module ptr_sync (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire fifo_types_pkg::ptr_t   gray_in,
  output fifo_types_pkg::ptr_t        bin_out
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  ptr_t gray_meta;
  ptr_t gray_sync;
  ptr_t bin_comb;

  // Two-flop synchronizer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // Gray to binary, from the top bit down.
  always_comb begin
    bin_comb[PTR_WIDTH-1] = gray_sync[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin_comb[i] = bin_comb[i+1] ^ gray_sync[i];
    end
  end

  // Registered binary result.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bin_out <= '0;
    end else begin
      bin_out <= bin_comb;
    end
  end

endmodule

`default_nettype wire

// ==== source/fifo_wr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo_wr_ctrl (
  input  wire                         wr_clk,
  input  wire                         wr_rst_n,
  input  wire                         wr_en,
  input  wire fifo_types_pkg::ptr_t   rd_ptr_sync,
  output logic                        wr_accept,
  output fifo_types_pkg::addr_t       wr_addr,
  output fifo_types_pkg::ptr_t        wr_ptr_gray,
  output logic                        full,
  output logic                        afull
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  ptr_t   wr_ptr;
  ptr_t   wr_ptr_nxt;
  ptr_t   wr_gray_nxt;
  level_t wr_level;
  logic   full_nxt;
  logic   afull_nxt;

  // Writes while full are dropped.
  assign wr_accept = wr_en & ~full;

  always_comb begin
    if (wr_accept) begin
      wr_ptr_nxt = wr_ptr + ptr_t'(1);
    end else begin
      wr_ptr_nxt = wr_ptr;
    end
  end

  // Binary to Gray.
  assign wr_gray_nxt = wr_ptr_nxt ^ (wr_ptr_nxt >> 1);

  // Memory address drops the wrap bit.
  assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;
    end
  end

  // Never below the true level, since the read pointer lags.
  assign wr_level = level_t'(wr_ptr_nxt - rd_ptr_sync);

  assign full_nxt  = (wr_level == level_t'(FIFO_DEPTH));
  assign afull_nxt = (wr_level >= level_t'(FIFO_AFULL));

  // Flags set on the edge that takes the word.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/fifo_rd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo_rd_ctrl (
  input  wire                         rd_clk,
  input  wire                         wr_rst_n,
  input  wire                         rd_en,
  input  wire fifo_types_pkg::ptr_t   wr_ptr_sync,
  output logic                        rd_rst_n,
  output logic                        rd_accept,
  output fifo_types_pkg::addr_t       rd_addr,
  output fifo_types_pkg::ptr_t        rd_ptr_gray,
  output logic                        empty,
  output logic                        aempty
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  logic   rst_meta;
  ptr_t   rd_ptr;
  ptr_t   rd_ptr_nxt;
  ptr_t   rd_gray_nxt;
  level_t rd_level;
  logic   empty_nxt;
  logic   aempty_nxt;

  // Asserts at once, releases on rd_clk.
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_meta <= 1'b0;
      rd_rst_n <= 1'b0;
    end else begin
      rst_meta <= 1'b1;
      rd_rst_n <= rst_meta;
    end
  end

  // Reads while empty are ignored.
  assign rd_accept = rd_en & ~empty;

  always_comb begin
    if (rd_accept) begin
      rd_ptr_nxt = rd_ptr + ptr_t'(1);
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  // Binary to Gray.
  assign rd_gray_nxt = rd_ptr_nxt ^ (rd_ptr_nxt >> 1);

  assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // Never above the true level, since the write pointer lags.
  assign rd_level = level_t'(wr_ptr_sync - rd_ptr_nxt);

  assign empty_nxt  = (rd_level == '0);
  assign aempty_nxt = (rd_level <= level_t'(FIFO_AEMPTY));

  // Empty after reset.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo (
  input  wire                         wr_clk,
  input  wire                         wr_rst_n,
  input  wire                         wr_en,
  input  wire fifo_types_pkg::data_t  wr_data,
  input  wire                         rd_clk,
  input  wire                         rd_en,
  output fifo_types_pkg::data_t       rd_data,
  output logic                        full,
  output logic                        afull,
  output logic                        empty,
  output logic                        aempty
);

  import fifo_types_pkg::*;

  // Write domain.
  logic  wr_accept;
  addr_t wr_addr;
  ptr_t  wr_ptr_gray;
  ptr_t  rd_ptr_sync;

  // Read domain.
  logic  rd_rst_n;
  logic  rd_accept;
  addr_t rd_addr;
  ptr_t  rd_ptr_gray;
  ptr_t  wr_ptr_sync;

  fifo_ram u_ram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_sync (rd_ptr_sync),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .wr_rst_n    (wr_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_rst_n    (rd_rst_n),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  // Write pointer into the read domain.
  ptr_sync wr_to_rd_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_ptr_gray),
    .bin_out (wr_ptr_sync)
  );

  // Read pointer into the write domain.
  ptr_sync rd_to_wr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_ptr_gray),
    .bin_out (rd_ptr_sync)
  );

endmodule

`default_nettype wire

// ==== bench/fifo_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo_checker (
  input wire                         wr_clk,
  input wire                         wr_rst_n,
  input wire fifo_types_pkg::ptr_t   wr_ptr_gray,
  input wire                         full,
  input wire                         afull,
  input wire                         rd_clk,
  input wire                         rd_rst_n,
  input wire fifo_types_pkg::ptr_t   rd_ptr_gray,
  input wire                         empty,
  input wire                         aempty
);

  int assert_fails = 0;

  // Full is the top of the almost-full range.
  full_in_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull)
    else begin
      $error("full is set while afull is clear");
      assert_fails++;
    end

  empty_in_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty)
    else begin
      $error("empty is set while aempty is clear");
      assert_fails++;
    end

  // A dropped write leaves the pointer where it was.
  no_write_when_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
                                       full |=> $stable(wr_ptr_gray))
    else begin
      $error("the write pointer moved while the FIFO was full");
      assert_fails++;
    end

  no_read_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
                                       empty |=> $stable(rd_ptr_gray))
    else begin
      $error("the read pointer moved while the FIFO was empty");
      assert_fails++;
    end

endmodule

bind async_fifo fifo_checker u_checker (
  .wr_clk      (wr_clk),
  .wr_rst_n    (wr_rst_n),
  .wr_ptr_gray (wr_ptr_gray),
  .full        (full),
  .afull       (afull),
  .rd_clk      (rd_clk),
  .rd_rst_n    (rd_rst_n),
  .rd_ptr_gray (rd_ptr_gray),
  .empty       (empty),
  .aempty      (aempty)
);

`default_nettype wire

// ==== bench/fifo_scoreboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module fifo_scoreboard (
  input wire                         wr_clk,
  input wire                         wr_rst_n,
  input wire                         wr_en,
  input wire fifo_types_pkg::data_t  wr_data,
  input wire                         rd_clk,
  input wire                         rd_en,
  input wire fifo_types_pkg::data_t  rd_data,
  input wire                         full,
  input wire                         afull,
  input wire                         empty,
  input wire                         aempty
);

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  data_t model_q[$];
  data_t exp_word;
  data_t last_word;
  logic  pending = 1'b0;
  logic  have_last = 1'b0;
  int    error_count = 0;
  string test_name = "none";

  task automatic start_test(input string name);
    test_name = name;
  endtask

  // Accepted writes, as seen on the ports.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
    end
  end

  // Word of an accepted read shows up one rd_clk later.
  always @(posedge rd_clk) begin
    if (pending) begin
      if (rd_data !== exp_word) begin
        $display("[ERROR] %s: expected %h, actual %h", test_name, exp_word, rd_data);
        error_count++;
      end
      last_word = rd_data;
      have_last = 1'b1;
    end else if (have_last && rd_data !== last_word) begin
      $display("[ERROR] %s: held rd_data expected %h, actual %h", test_name, last_word, rd_data);
      error_count++;
    end
    pending = 1'b0;
    if (wr_rst_n && rd_en && !empty) begin
      if (model_q.size() == 0) begin
        $display("Error in %s: a read was accepted with no word left to read", test_name);
        error_count++;
      end else begin
        exp_word = model_q.pop_front();
        pending = 1'b1;
      end
    end
  end

  // Flags are ordered full, afull, empty, aempty.
  task automatic check_flags(input logic [3:0] exp_flags);
    logic [3:0] act;
    logic [3:0] model;
    int         level;
    level = model_q.size();
    act = {full, afull, empty, aempty};
    model = {level == FIFO_DEPTH, level >= FIFO_AFULL, level == 0, level <= FIFO_AEMPTY};
    if (act !== exp_flags) begin
      $display("[ERROR] %s: flags expected %b, actual %b", test_name, exp_flags, act);
      error_count++;
    end
    if (act !== model) begin
      $display("[ERROR] %s: flags at level %0d expected %b, actual %b",
               test_name, level, model, act);
      error_count++;
    end
  endtask

endmodule

`default_nettype wire

// ==== bench/async_fifo_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo_tb;

  import fifo_cfg_pkg::*;
  import fifo_types_pkg::*;

  localparam int RD_PERIOD      = 100;
  localparam int WR_PERIOD      = 70;
  localparam int DRIVE_DELAY    = 5;
  localparam int HOLD_LIMIT     = 40;
  localparam int SETTLE_CYCLES  = 8;
  localparam int SETTLE_TIMEOUT = 200;

  typedef struct {
    string      name;
    int         n_wr;
    int         n_rd;
    int         wr_duty;
    int         rd_duty;
    logic [3:0] flags;
  } row_t;

  logic  rd_clk;
  logic  wr_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_en;
  data_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  row_t        rows[$];
  int          timeouts;
  int unsigned seed_val;

  always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

  async_fifo dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  fifo_scoreboard scoreboard (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Flags are ordered full, afull, empty, aempty.
  function automatic void add_row(input string name, input int n_wr, input int n_rd,
                                  input int wr_duty, input int rd_duty,
                                  input logic [3:0] flags);
    row_t r;
    r.name    = name;
    r.n_wr    = n_wr;
    r.n_rd    = n_rd;
    r.wr_duty = wr_duty;
    r.rd_duty = rd_duty;
    r.flags   = flags;
    rows.push_back(r);
  endfunction

  // Each word is held until taken, or dropped after HOLD_LIMIT cycles.
  task automatic write_words(input int count, input int duty);
    int   sent;
    int   hold;
    logic taken;
    sent = 0;
    @(posedge wr_clk);
    #DRIVE_DELAY;
    while (sent < count) begin
      if ($urandom_range(99) < duty) begin
        wr_data = data_t'($urandom);
        wr_en = 1'b1;
        hold = 0;
        taken = 1'b0;
        while (!taken && hold < HOLD_LIMIT) begin
          @(posedge wr_clk);
          taken = !full;
          hold++;
          #DRIVE_DELAY;
        end
        wr_en = 1'b0;
        sent++;
      end else begin
        @(posedge wr_clk);
        #DRIVE_DELAY;
      end
    end
  endtask

  task automatic read_words(input int count, input int duty);
    int   done;
    int   hold;
    logic taken;
    done = 0;
    @(posedge rd_clk);
    #DRIVE_DELAY;
    while (done < count) begin
      if ($urandom_range(99) < duty) begin
        rd_en = 1'b1;
        hold = 0;
        taken = 1'b0;
        while (!taken && hold < HOLD_LIMIT) begin
          @(posedge rd_clk);
          taken = !empty;
          hold++;
          #DRIVE_DELAY;
        end
        rd_en = 1'b0;
        done++;
      end else begin
        @(posedge rd_clk);
        #DRIVE_DELAY;
      end
    end
  endtask

  // Idle until the flags hold still for SETTLE_CYCLES.
  task automatic settle_flags(input string name);
    logic [3:0] prev;
    int         stable;
    int         waited;
    prev = {full, afull, empty, aempty};
    stable = 0;
    waited = 0;
    while (stable < SETTLE_CYCLES && waited < SETTLE_TIMEOUT) begin
      @(posedge rd_clk);
      waited++;
      if ({full, afull, empty, aempty} === prev) begin
        stable++;
      end else begin
        stable = 0;
        prev = {full, afull, empty, aempty};
      end
    end
    if (stable < SETTLE_CYCLES) begin
      $display("Timeout: flags still changing %0d cycles after %s", waited, name);
      timeouts++;
    end
    #DRIVE_DELAY;
  endtask

  initial begin
    seed_val = $urandom(57);
    rd_clk = 1'b0;
    wr_clk = 1'b0;
    wr_rst_n = 1'b0;
    wr_en = 1'b0;
    wr_data = '0;
    rd_en = 1'b0;
    timeouts = 0;

    add_row("reset",      0,   0,   0,   0, 4'b0011);
    add_row("fill",      20,   0, 100,   0, 4'b1100);
    add_row("drain",      0,  24,   0, 100, 4'b0011);
    add_row("level_1",    1,   0, 100,   0, 4'b0001);
    add_row("level_2",    1,   0, 100,   0, 4'b0001);
    add_row("level_3",    1,   0, 100,   0, 4'b0000);
    add_row("level_13",  10,   0,  60,   0, 4'b0000);
    add_row("level_14",   1,   0, 100,   0, 4'b0100);
    add_row("level_16",   2,   0, 100,   0, 4'b1100);
    add_row("drain_all",  0,  20,   0,  80, 4'b0011);
    add_row("mixed",     40,  40,  50,  70, 4'b0011);
    add_row("wrap",     100, 100,  70,  40, 4'b0011);
    add_row("mixed_end", 30,  20,  90,  30, 4'b0000);

    repeat (16) @(posedge rd_clk);
    @(posedge wr_clk);
    #DRIVE_DELAY;
    wr_rst_n = 1'b1;

    foreach (rows[i]) begin
      scoreboard.start_test(rows[i].name);
      fork
        write_words(rows[i].n_wr, rows[i].wr_duty);
        read_words(rows[i].n_rd, rows[i].rd_duty);
      join
      settle_flags(rows[i].name);
      scoreboard.check_flags(rows[i].flags);
    end

    $display("Errors: %0d compare, %0d timeout, %0d assertion",
             scoreboard.error_count, timeouts, dut.u_checker.assert_fails);
    if (scoreboard.error_count == 0 && timeouts == 0 && dut.u_checker.assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/fifo_cfg_pkg.sv
source/fifo_types_pkg.sv
source/fifo_ram.sv
source/ptr_sync.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/async_fifo.sv
bench/fifo_checker.sv
bench/fifo_scoreboard.sv
bench/async_fifo_tb.sv
